// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // ----------------------------------------------------------------------
    // Bus and UART field types
    // ----------------------------------------------------------------------
    typedef logic [31:0] addr_t;    // HADDR
    typedef logic [31:0] data_t;    // HWDATA / HRDATA
    typedef logic [1:0]  trans_t;   // HTRANS
    typedef logic [2:0]  size_t;    // HSIZE, 0 byte 1 half 2 word
    typedef logic [7:0]  byte_t;    // One UART character
    typedef logic [15:0] div_t;     // Clocks per UART bit

    localparam trans_t HTRANS_IDLE   = 2'b00;
    localparam trans_t HTRANS_NONSEQ = 2'b10;   // Only single transfers used

    // Slot number lives in haddr[15:12]
    localparam logic [3:0] SLOT_SRAM = 4'd0;
    localparam logic [3:0] SLOT_GPIO = 4'd1;
    localparam logic [3:0] SLOT_UART = 4'd2;

    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);     // Word index from haddr[11:2]

    // Register offsets, haddr[3:0]
    localparam logic [3:0] GPIO_OUT_OFS  = 4'h0;
    localparam logic [3:0] GPIO_OE_OFS   = 4'h4;
    localparam logic [3:0] GPIO_IN_OFS   = 4'h8;
    localparam logic [3:0] UART_TX_OFS   = 4'h0;
    localparam logic [3:0] UART_RX_OFS   = 4'h4;
    localparam logic [3:0] UART_STAT_OFS = 4'h8;
    localparam logic [3:0] UART_DIV_OFS  = 4'hC;

    localparam div_t UART_DIV_RESET = 16'd16;

endpackage

`default_nettype wire

// ==== ahb_if.sv ====
`default_nettype none

interface ahb_if;
    import soc_pkg::*;

    // Address phase, from the decoder
    logic   hsel;
    addr_t  haddr;
    trans_t htrans;
    logic   hwrite;
    size_t  hsize;
    data_t  hwdata;         // Data phase write data
    logic   hready;         // Bus ready, same for every slave

    // Response, from the slave
    data_t  hrdata;
    logic   hreadyout;
    logic   hresp;          // 1 = error

    modport decoder
    (
        output hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
        input  hrdata, hreadyout, hresp
    );

    modport slave
    (
        input  hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
        output hrdata, hreadyout, hresp
    );

endinterface

`default_nettype wire

// ==== ahb_decoder.sv ====
`default_nettype none

module ahb_decoder
(
    input  logic            clk,
    input  logic            RSTn,
    input  logic            i_hsel,
    input  soc_pkg::addr_t  i_haddr,
    input  soc_pkg::trans_t i_htrans,
    input  logic            i_hwrite,
    input  soc_pkg::size_t  i_hsize,
    input  soc_pkg::data_t  i_hwdata,
    output logic            o_hready,
    output soc_pkg::data_t  o_hrdata,
    output logic            o_hresp,
    ahb_if.decoder          m_sram,
    ahb_if.decoder          m_gpio,
    ahb_if.decoder          m_uart
);
    import soc_pkg::*;

    typedef enum logic [1:0] {ERR_IDLE, ERR_FIRST, ERR_SECOND} err_state_t;

    err_state_t err_state;
    logic [3:0] a_slot;         // Address-phase slot
    logic [3:0] d_slot;         // Data-phase slot
    logic       d_valid;        // Mapped transfer in data phase
    logic       a_mapped;
    logic       accept;
    logic       sel_sram, sel_gpio, sel_uart;
    logic       ready_mux, resp_mux;

    assign a_slot   = i_haddr[15:12];
    assign a_mapped = (a_slot == SLOT_SRAM) || (a_slot == SLOT_GPIO) || (a_slot == SLOT_UART);
    assign accept   = i_hsel && (i_htrans == HTRANS_NONSEQ) && o_hready;

    assign sel_sram = i_hsel && (a_slot == SLOT_SRAM);
    assign sel_gpio = i_hsel && (a_slot == SLOT_GPIO);
    assign sel_uart = i_hsel && (a_slot == SLOT_UART);

    // ----------------------------------------------------------------------
    // Address-phase fan-out, only hsel/htrans differ per slave
    // ----------------------------------------------------------------------
    assign m_sram.hsel   = sel_sram;
    assign m_sram.htrans = sel_sram ? i_htrans : HTRANS_IDLE;
    assign m_sram.haddr  = i_haddr;
    assign m_sram.hwrite = i_hwrite;
    assign m_sram.hsize  = i_hsize;
    assign m_sram.hwdata = i_hwdata;
    assign m_sram.hready = o_hready;

    assign m_gpio.hsel   = sel_gpio;
    assign m_gpio.htrans = sel_gpio ? i_htrans : HTRANS_IDLE;
    assign m_gpio.haddr  = i_haddr;
    assign m_gpio.hwrite = i_hwrite;
    assign m_gpio.hsize  = i_hsize;
    assign m_gpio.hwdata = i_hwdata;
    assign m_gpio.hready = o_hready;

    assign m_uart.hsel   = sel_uart;
    assign m_uart.htrans = sel_uart ? i_htrans : HTRANS_IDLE;
    assign m_uart.haddr  = i_haddr;
    assign m_uart.hwrite = i_hwrite;
    assign m_uart.hsize  = i_hsize;
    assign m_uart.hwdata = i_hwdata;
    assign m_uart.hready = o_hready;

    // Data-phase slot, advances only when the bus is ready
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_valid <= 1'b0;
            d_slot  <= SLOT_SRAM;
        end
        else if (o_hready)
        begin
            d_valid <= accept && a_mapped;
            d_slot  <= a_slot;
        end
    end

    // Default slave: two-cycle error for unmapped slots
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            err_state <= ERR_IDLE;
        else
        begin
            case (err_state)
                ERR_FIRST: err_state <= ERR_SECOND;     // hready low this cycle
                default:   err_state <= (accept && !a_mapped) ? ERR_FIRST : ERR_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Response multiplexer
    // ----------------------------------------------------------------------
    always_comb
    begin
        o_hrdata  = '0;
        ready_mux = 1'b1;       // Idle bus is ready
        resp_mux  = 1'b0;
        if (d_valid)
        begin
            case (d_slot)
                SLOT_SRAM:
                begin
                    o_hrdata  = m_sram.hrdata;
                    ready_mux = m_sram.hreadyout;
                    resp_mux  = m_sram.hresp;
                end
                SLOT_GPIO:
                begin
                    o_hrdata  = m_gpio.hrdata;
                    ready_mux = m_gpio.hreadyout;
                    resp_mux  = m_gpio.hresp;
                end
                default:
                begin
                    o_hrdata  = m_uart.hrdata;
                    ready_mux = m_uart.hreadyout;
                    resp_mux  = m_uart.hresp;
                end
            endcase
        end
    end

    assign o_hready = (err_state == ERR_FIRST) ? 1'b0 : ready_mux;
    assign o_hresp  = (err_state != ERR_IDLE) || resp_mux;

endmodule

`default_nettype wire

// ==== ahb_sram.sv ====
`default_nettype none

module ahb_sram
(
    input  logic    clk,
    input  logic    RSTn,
    ahb_if.slave    s_bus
);
    import soc_pkg::*;

    data_t                 mem [SRAM_WORDS];
    logic                  accept;
    logic                  d_active;    // Transfer in data phase
    logic                  d_write;
    logic [SRAM_IDX_W-1:0] d_idx;
    logic [1:0]            d_lane;      // haddr[1:0]
    size_t                 d_size;
    logic [3:0]            lane_en;

    assign accept = s_bus.hsel && (s_bus.htrans == HTRANS_NONSEQ) && s_bus.hready;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_active <= 1'b0;
            d_write  <= 1'b0;
        end
        else if (s_bus.hready)
        begin
            d_active <= accept;
            d_write  <= accept && s_bus.hwrite;
        end
    end

    // Address-phase capture
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            d_idx  <= s_bus.haddr[SRAM_IDX_W+1:2];
            d_lane <= s_bus.haddr[1:0];
            d_size <= s_bus.hsize;
        end
    end

    // Byte lanes from size and low address
    always_comb
    begin
        case (d_size)
            3'd0:    lane_en = 4'b0001 << d_lane;
            3'd1:    lane_en = d_lane[1] ? 4'b1100 : 4'b0011;
            default: lane_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (d_write && s_bus.hready)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (lane_en[b])
                    mem[d_idx][8*b +: 8] <= s_bus.hwdata[8*b +: 8];
            end
        end
    end

    assign s_bus.hrdata    = d_active ? mem[d_idx] : '0;   // Whole word, master picks lanes
    assign s_bus.hreadyout = 1'b1;      // Zero wait
    assign s_bus.hresp     = 1'b0;

endmodule

`default_nettype wire

// ==== ahb_gpio.sv ====
`default_nettype none

module ahb_gpio
(
    input  logic            clk,
    input  logic            RSTn,
    ahb_if.slave            s_bus,
    input  soc_pkg::data_t  i_gpio_in,
    output soc_pkg::data_t  o_gpio_out,
    output soc_pkg::data_t  o_gpio_oe
);
    import soc_pkg::*;

    logic       accept;
    logic       d_active;
    logic       d_write;
    logic [3:0] d_ofs;      // Latched register offset
    data_t      in_meta;    // Synchronizer stage 1
    data_t      in_sync;    // Stage 2, read as IN

    assign accept = s_bus.hsel && (s_bus.htrans == HTRANS_NONSEQ) && s_bus.hready;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_active <= 1'b0;
            d_write  <= 1'b0;
            d_ofs    <= '0;
        end
        else if (s_bus.hready)
        begin
            d_active <= accept;
            d_write  <= accept && s_bus.hwrite;
            d_ofs    <= s_bus.haddr[3:0];
        end
    end

    // OUT and OE, whole-word writes
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            o_gpio_out <= '0;
            o_gpio_oe  <= '0;       // All pins input
        end
        else if (d_write && s_bus.hready)
        begin
            if (d_ofs == GPIO_OUT_OFS)
                o_gpio_out <= s_bus.hwdata;
            if (d_ofs == GPIO_OE_OFS)
                o_gpio_oe <= s_bus.hwdata;
        end
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= i_gpio_in;
            in_sync <= in_meta;
        end
    end

    // Read mux
    always_comb
    begin
        s_bus.hrdata = '0;
        if (d_active)
        begin
            case (d_ofs)
                GPIO_OUT_OFS: s_bus.hrdata = o_gpio_out;
                GPIO_OE_OFS:  s_bus.hrdata = o_gpio_oe;
                GPIO_IN_OFS:  s_bus.hrdata = in_sync;
                default:      s_bus.hrdata = '0;
            endcase
        end
    end

    assign s_bus.hreadyout = 1'b1;
    assign s_bus.hresp     = 1'b0;

endmodule

`default_nettype wire

// ==== uart_regs.sv ====
`default_nettype none

module uart_regs
(
    input  logic            clk,
    input  logic            RSTn,
    ahb_if.slave            s_bus,
    output logic            o_tx_start,
    output soc_pkg::byte_t  o_tx_byte,
    output soc_pkg::div_t   o_div,
    input  logic            i_tx_busy,
    input  logic            i_rx_done,
    input  soc_pkg::byte_t  i_rx_byte,
    output logic            o_irq
);
    import soc_pkg::*;

    logic       accept;
    logic       d_active;
    logic       d_write;
    logic [3:0] d_ofs;
    logic       wr_en;      // Data-phase write completes
    logic       rd_en;      // Data-phase read completes
    logic       rx_valid;   // Unread byte in RX
    byte_t      rx_byte;

    assign accept = s_bus.hsel && (s_bus.htrans == HTRANS_NONSEQ) && s_bus.hready;
    assign wr_en  = d_write && s_bus.hready;
    assign rd_en  = d_active && !d_write && s_bus.hready;

    // ----------------------------------------------------------------------
    // Transmit side
    // ----------------------------------------------------------------------
    assign o_tx_start = wr_en && (d_ofs == UART_TX_OFS) && !i_tx_busy;  // Dropped when busy
    assign o_tx_byte  = s_bus.hwdata[7:0];
    assign o_irq      = rx_valid;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_active <= 1'b0;
            d_write  <= 1'b0;
            d_ofs    <= '0;
            o_div    <= UART_DIV_RESET;
            rx_valid <= 1'b0;
        end
        else
        begin
            if (s_bus.hready)
            begin
                d_active <= accept;
                d_write  <= accept && s_bus.hwrite;
                d_ofs    <= s_bus.haddr[3:0];
            end
            if (wr_en && (d_ofs == UART_DIV_OFS))
                o_div <= s_bus.hwdata[15:0];
            // New byte wins over a read in the same cycle
            if (i_rx_done)
                rx_valid <= 1'b1;
            else if (rd_en && (d_ofs == UART_RX_OFS))
                rx_valid <= 1'b0;
        end
    end

    // Receive buffer, overwritten by each new byte
    always_ff @(posedge clk)
    begin
        if (i_rx_done)
            rx_byte <= i_rx_byte;
    end

    always_comb
    begin
        s_bus.hrdata = '0;
        if (d_active)
        begin
            case (d_ofs)
                UART_RX_OFS:   s_bus.hrdata = {24'd0, rx_byte};
                UART_STAT_OFS: s_bus.hrdata = {30'd0, rx_valid, i_tx_busy};
                UART_DIV_OFS:  s_bus.hrdata = {16'd0, o_div};
                default:       s_bus.hrdata = '0;     // TX reads as zero
            endcase
        end
    end

    assign s_bus.hreadyout = 1'b1;
    assign s_bus.hresp     = 1'b0;

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx
(
    input  logic            clk,
    input  logic            RSTn,
    input  logic            i_start,
    input  soc_pkg::byte_t  i_byte,
    input  soc_pkg::div_t   i_div,
    output logic            o_busy,
    output logic            o_txd
);
    import soc_pkg::*;

    logic [9:0] shreg;      // {stop, data[7:0], start}, LSB on the line
    logic [3:0] bit_cnt;
    div_t       div_cnt;
    logic       bit_end;

    assign bit_end = (div_cnt == div_t'(i_div - 16'd1));
    assign o_txd   = shreg[0];          // Line idles high

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            shreg   <= '1;
            bit_cnt <= '0;
            div_cnt <= '0;
            o_busy  <= 1'b0;
        end
        else if (!o_busy)
        begin
            if (i_start)
            begin
                shreg   <= {1'b1, i_byte, 1'b0};
                bit_cnt <= '0;
                div_cnt <= '0;
                o_busy  <= 1'b1;
            end
        end
        else if (bit_end)
        begin
            div_cnt <= '0;
            shreg   <= {1'b1, shreg[9:1]};  // Back-fill ones
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9)            // Stop bit done
                o_busy <= 1'b0;
        end
        else
            div_cnt <= div_cnt + 16'd1;
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx
(
    input  logic            clk,
    input  logic            RSTn,
    input  logic            i_rxd,
    input  soc_pkg::div_t   i_div,
    output logic            o_done,
    output soc_pkg::byte_t  o_byte
);
    import soc_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic       rxd_meta, rxd_sync, rxd_prev;
    div_t       cnt;
    div_t       half_div;
    logic [2:0] bit_cnt;
    byte_t      shreg;
    logic       full_hit;   // One bit time elapsed
    logic       half_hit;   // Middle of start bit

    assign half_div = i_div >> 1;
    assign full_hit = (cnt == div_t'(i_div - 16'd1));
    assign half_hit = (cnt == div_t'(half_div - 16'd1));

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;      // For edge detect
        end
    end

    // ----------------------------------------------------------------------
    // Frame FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            o_done  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            cnt    <= cnt + 16'd1;
            case (state)
                RX_IDLE:
                begin
                    cnt <= '0;
                    if (rxd_prev && !rxd_sync)
                        state <= RX_START;
                end
                RX_START:
                    if (half_hit)
                    begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;   // Glitch rejected
                    end
                RX_DATA:
                    if (full_hit)
                    begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                default:
                    if (full_hit)
                    begin
                        state  <= RX_IDLE;
                        o_done <= rxd_sync;     // Bad stop bit drops the frame
                    end
            endcase
        end
    end

    // Data path, LSB first
    always_ff @(posedge clk)
    begin
        if ((state == RX_DATA) && full_hit)
            shreg <= {rxd_sync, shreg[7:1]};
        if ((state == RX_STOP) && full_hit && rxd_sync)
            o_byte <= shreg;
    end

endmodule

`default_nettype wire

// ==== periph_top.sv ====
`default_nettype none

module periph_top
(
    input  logic            clk,
    input  logic            RSTn,
    input  logic            i_hsel,
    input  soc_pkg::addr_t  i_haddr,
    input  soc_pkg::trans_t i_htrans,
    input  logic            i_hwrite,
    input  soc_pkg::size_t  i_hsize,
    input  soc_pkg::data_t  i_hwdata,
    input  soc_pkg::data_t  i_gpio_in,
    input  logic            i_rxd,
    output logic            o_hready,
    output soc_pkg::data_t  o_hrdata,
    output logic            o_hresp,
    output soc_pkg::data_t  o_gpio_out,
    output soc_pkg::data_t  o_gpio_oe,
    output logic            o_txd,
    output logic            o_irq
);
    import soc_pkg::*;

    logic  tx_start;
    logic  tx_busy;
    logic  rx_done;
    byte_t tx_byte;
    byte_t rx_byte;
    div_t  div;         // Clocks per bit, from the UART registers

    ahb_if bus_sram ();
    ahb_if bus_gpio ();
    ahb_if bus_uart ();

    // ----------------------------------------------------------------------
    // Bus fabric and slaves
    // ----------------------------------------------------------------------
    ahb_decoder i_ahb_decoder
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_hsel     (i_hsel),
        .i_haddr    (i_haddr),
        .i_htrans   (i_htrans),
        .i_hwrite   (i_hwrite),
        .i_hsize    (i_hsize),
        .i_hwdata   (i_hwdata),
        .o_hready   (o_hready),
        .o_hrdata   (o_hrdata),
        .o_hresp    (o_hresp),
        .m_sram     (bus_sram.decoder),
        .m_gpio     (bus_gpio.decoder),
        .m_uart     (bus_uart.decoder)
    );

    ahb_sram i_ahb_sram
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .s_bus      (bus_sram.slave)
    );

    ahb_gpio i_ahb_gpio
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .s_bus      (bus_gpio.slave),
        .i_gpio_in  (i_gpio_in),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe)
    );

    uart_regs i_uart_regs
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .s_bus      (bus_uart.slave),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .o_div      (div),
        .i_tx_busy  (tx_busy),
        .i_rx_done  (rx_done),
        .i_rx_byte  (rx_byte),
        .o_irq      (o_irq)
    );

    // Serial engines share the one divisor
    uart_tx i_uart_tx
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_start    (tx_start),
        .i_byte     (tx_byte),
        .i_div      (div),
        .o_busy     (tx_busy),
        .o_txd      (o_txd)
    );

    uart_rx i_uart_rx
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_rxd      (i_rxd),
        .i_div      (div),
        .o_done     (rx_done),
        .o_byte     (rx_byte)
    );

endmodule

`default_nettype wire

// ==== tb_periph.sv ====
`default_nettype none

module tb_periph;
    import soc_pkg::*;

    localparam int MAX_CYCLES = 20000;  // Run needs ~2k cycles, frames dominate
    localparam int N_WORDS    = 16;     // Must stay 16, byte test picks with 4 bits
    localparam int N_BYTES    = 24;
    localparam int NEW_DIV    = 24;

    localparam addr_t GPIO_OUT_ADDR = {16'h0000, SLOT_GPIO, 8'h00, GPIO_OUT_OFS};
    localparam addr_t GPIO_OE_ADDR  = {16'h0000, SLOT_GPIO, 8'h00, GPIO_OE_OFS};
    localparam addr_t GPIO_IN_ADDR  = {16'h0000, SLOT_GPIO, 8'h00, GPIO_IN_OFS};
    localparam addr_t TX_ADDR       = {16'h0000, SLOT_UART, 8'h00, UART_TX_OFS};
    localparam addr_t RX_ADDR       = {16'h0000, SLOT_UART, 8'h00, UART_RX_OFS};
    localparam addr_t STAT_ADDR     = {16'h0000, SLOT_UART, 8'h00, UART_STAT_OFS};
    localparam addr_t DIV_ADDR      = {16'h0000, SLOT_UART, 8'h00, UART_DIV_OFS};

    logic   clk;
    logic   RSTn;
    logic   i_hsel;
    addr_t  i_haddr;
    trans_t i_htrans;
    logic   i_hwrite;
    size_t  i_hsize;
    data_t  i_hwdata;
    data_t  i_gpio_in;
    logic   o_hready;
    data_t  o_hrdata;
    logic   o_hresp;
    data_t  o_gpio_out;
    data_t  o_gpio_oe;
    logic   o_txd;
    logic   o_irq;

    integer                seed;
    int                    cycle_cnt = 0;
    data_t                 sram_ref [SRAM_WORDS];  // Expected SRAM contents
    logic [SRAM_IDX_W-1:0] used_idx [$];           // Word indices written so far
    data_t                 gpio_out_ref;
    data_t                 gpio_oe_ref;

    periph_top i_periph_top
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_hsel     (i_hsel),
        .i_haddr    (i_haddr),
        .i_htrans   (i_htrans),
        .i_hwrite   (i_hwrite),
        .i_hsize    (i_hsize),
        .i_hwdata   (i_hwdata),
        .i_gpio_in  (i_gpio_in),
        .i_rxd      (o_txd),        // Serial loopback
        .o_hready   (o_hready),
        .o_hrdata   (o_hrdata),
        .o_hresp    (o_hresp),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe),
        .o_txd      (o_txd),
        .o_irq      (o_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and watchdog
    // ----------------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input data_t got, input data_t exp, input string what);
        assert (got === exp)
        else stop_with_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, what, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            stop_with_failure("timeout: the run did not finish within the cycle limit");
    end

    task automatic next_random(output data_t v);
        v = $random(seed);
    endtask

    // Lane merge: byte at ofs, half at ofs[1], else whole word
    function automatic data_t merge_lanes(input data_t old, input data_t wdata,
                                          input size_t size, input logic [1:0] ofs);
        data_t mask;
        case (size)
            3'd0:    mask = 32'h0000_00FF << (8 * ofs);
            3'd1:    mask = ofs[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default: mask = 32'hFFFF_FFFF;
        endcase
        merge_lanes = (old & ~mask) | (wdata & mask);
    endfunction

    // ----------------------------------------------------------------------
    // Bus master
    // ----------------------------------------------------------------------
    task automatic start_address(input addr_t addr, input logic write, input size_t size);
        @(posedge clk);
        i_hsel   <= 1'b1;
        i_haddr  <= addr;
        i_htrans <= HTRANS_NONSEQ;
        i_hwrite <= write;
        i_hsize  <= size;
        @(posedge clk);                 // Accepted, previous phase left hready high
        i_hsel   <= 1'b0;
        i_htrans <= HTRANS_IDLE;
    endtask

    task automatic finish_data_phase(output data_t rdata);
        @(negedge clk);
        while (!o_hready)
            @(negedge clk);
        assert (o_hresp === 1'b0)
        else stop_with_failure($sformatf("mismatch at %0t: error response on mapped slot",
                                         $time));
        rdata = o_hrdata;
    endtask

    task automatic bus_write(input addr_t addr, input size_t size, input data_t data);
        data_t ignored;
        start_address(addr, 1'b1, size);
        i_hwdata <= data;               // Data phase
        finish_data_phase(ignored);
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        start_address(addr, 1'b0, 3'd2);
        finish_data_phase(data);
    endtask

    task automatic read_check(input addr_t addr, input data_t exp, input string what);
        data_t got;
        bus_read(addr, got);
        check_equal(got, exp, what);
    endtask

    // ----------------------------------------------------------------------
    // SRAM and GPIO
    // ----------------------------------------------------------------------
    task automatic test_sram();
        data_t                 rnd;
        data_t                 wdata;
        logic [SRAM_IDX_W-1:0] idx;
        logic [1:0]            ofs;
        size_t                 size;
        for (int i = 0; i < N_WORDS; i++)
        begin
            next_random(rnd);
            next_random(wdata);
            idx = rnd[SRAM_IDX_W-1:0];
            bus_write({16'h0000, SLOT_SRAM, idx, 2'b00}, 3'd2, wdata);
            sram_ref[idx] = wdata;
            used_idx.push_back(idx);
        end
        for (int i = 0; i < N_BYTES; i++)
        begin
            next_random(rnd);
            next_random(wdata);
            idx  = used_idx[rnd[3:0]];  // Only words with known contents
            size = (rnd[5:4] == 2'd3) ? 3'd0 : {1'b0, rnd[5:4]};
            ofs  = rnd[7:6];
            if (size == 3'd1)
                ofs[0] = 1'b0;          // Halfword aligned
            if (size == 3'd2)
                ofs = 2'b00;
            bus_write({16'h0000, SLOT_SRAM, idx, ofs}, size, wdata);
            sram_ref[idx] = merge_lanes(sram_ref[idx], wdata, size, ofs);
            read_check({16'h0000, SLOT_SRAM, idx, 2'b00}, sram_ref[idx], "SRAM lane write");
        end
        foreach (used_idx[i])
            read_check({16'h0000, SLOT_SRAM, used_idx[i], 2'b00}, sram_ref[used_idx[i]],
                       "SRAM final sweep");
    endtask

    task automatic test_gpio();
        data_t rnd;
        for (int i = 0; i < 3; i++)
        begin
            next_random(gpio_out_ref);
            next_random(gpio_oe_ref);
            bus_write(GPIO_OUT_ADDR, 3'd2, gpio_out_ref);
            bus_write(GPIO_OE_ADDR, 3'd2, gpio_oe_ref);
            read_check(GPIO_OUT_ADDR, gpio_out_ref, "GPIO OUT readback");
            read_check(GPIO_OE_ADDR, gpio_oe_ref, "GPIO OE readback");
            check_equal(o_gpio_out, gpio_out_ref, "o_gpio_out pins");
            check_equal(o_gpio_oe, gpio_oe_ref, "o_gpio_oe pins");
            next_random(rnd);
            @(posedge clk);
            i_gpio_in <= rnd;
            repeat (3) @(posedge clk);  // Two sync flops plus one spare
            read_check(GPIO_IN_ADDR, rnd, "GPIO IN after sync");
        end
    endtask

    // ----------------------------------------------------------------------
    // UART
    // ----------------------------------------------------------------------
    task automatic wait_for_irq(input int limit);
        int n;
        n = 0;
        while (!o_irq && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        assert (o_irq === 1'b1)
        else stop_with_failure("receiver did not raise o_irq within one frame time");
    endtask

    task automatic wait_tx_idle(input int limit);
        data_t stat;
        int    n;
        n = 0;
        bus_read(STAT_ADDR, stat);
        while (stat[0] && n < limit)    // Poll STAT busy
        begin
            bus_read(STAT_ADDR, stat);
            n++;
        end
        assert (stat[0] === 1'b0)
        else stop_with_failure("transmitter stayed busy past the end of its frame");
    endtask

    task automatic uart_loopback(input byte_t b, input int div);
        data_t stat;
        bus_write(TX_ADDR, 3'd0, {24'd0, b});
        bus_read(STAT_ADDR, stat);
        check_equal({31'd0, stat[0]}, 32'd1, "STAT busy after TX write");
        wait_for_irq(12 * div + 20);
        bus_read(STAT_ADDR, stat);
        check_equal({31'd0, stat[1]}, 32'd1, "STAT rx_valid");
        read_check(RX_ADDR, {24'd0, b}, "RX byte");
        @(negedge clk);
        check_equal({31'd0, o_irq}, 32'd0, "o_irq after RX read");
        wait_tx_idle(div);
    endtask

    // Second byte while busy must be dropped
    task automatic test_busy_write(input int div);
        data_t rnd;
        data_t stat;
        next_random(rnd);
        bus_write(TX_ADDR, 3'd0, {24'd0, rnd[7:0]});
        bus_read(STAT_ADDR, stat);
        check_equal({31'd0, stat[0]}, 32'd1, "STAT busy before second TX write");
        bus_write(TX_ADDR, 3'd0, {24'd0, ~rnd[7:0]});
        wait_for_irq(12 * div + 20);
        read_check(RX_ADDR, {24'd0, rnd[7:0]}, "RX byte with dropped write");
        wait_tx_idle(div);
        for (int n = 0; n < 12 * div; n++)
        begin
            @(negedge clk);
            check_equal({31'd0, o_irq}, 32'd0, "o_irq after dropped TX write");
        end
    endtask

    // Slot 5, two-cycle error then normal SRAM access
    task automatic test_unmapped(input logic [SRAM_IDX_W-1:0] idx);
        start_address({16'h0000, 4'd5, 12'h000}, 1'b0, 3'd2);
        @(negedge clk);
        check_equal({30'd0, o_hresp, o_hready}, 32'd2, "error cycle one {hresp, hready}");
        @(negedge clk);
        check_equal({30'd0, o_hresp, o_hready}, 32'd3, "error cycle two {hresp, hready}");
        read_check({16'h0000, SLOT_SRAM, idx, 2'b00}, sram_ref[idx], "SRAM after error");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        data_t rnd;
        seed      = 3;
        RSTn      = 1'b0;
        i_hsel    = 1'b0;
        i_haddr   = '0;
        i_htrans  = HTRANS_IDLE;
        i_hwrite  = 1'b0;
        i_hsize   = 3'd2;
        i_hwdata  = '0;
        i_gpio_in = '0;
        repeat (2) @(posedge clk);
        RSTn <= 1'b1;
        @(negedge clk);
        check_equal({31'd0, o_hready}, 32'd1, "o_hready after reset");
        check_equal({31'd0, o_hresp}, 32'd0, "o_hresp after reset");
        check_equal({31'd0, o_txd}, 32'd1, "o_txd after reset");
        check_equal({31'd0, o_irq}, 32'd0, "o_irq after reset");
        check_equal(o_gpio_oe, '0, "o_gpio_oe after reset");
        check_equal(o_gpio_out, '0, "o_gpio_out after reset");

        test_sram();
        test_gpio();

        read_check(DIV_ADDR, {16'd0, UART_DIV_RESET}, "DIV after reset");
        for (int i = 0; i < 2; i++)
        begin
            next_random(rnd);
            uart_loopback(rnd[7:0], int'(UART_DIV_RESET));
        end
        bus_write(DIV_ADDR, 3'd2, NEW_DIV);
        read_check(DIV_ADDR, NEW_DIV, "DIV readback");
        for (int i = 0; i < 2; i++)
        begin
            next_random(rnd);
            uart_loopback(rnd[7:0], NEW_DIV);
        end
        test_busy_write(NEW_DIV);

        test_unmapped(used_idx[0]);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
soc_pkg.sv
ahb_if.sv
ahb_decoder.sv
ahb_sram.sv
ahb_gpio.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
periph_top.sv
tb_periph.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of tb_periph, pass decided from the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_periph -o sim_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_periph)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
